/* Makefile */
# Verilator flow for the user CSR block
# Run from the project root so the testbench finds its pattern file

VERILATOR ?= verilator
TOP       ?= userCsrTb
LINT_TOP  ?= userCsrTop
FILELIST  ?= files.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing
PASS_TEXT ?= ALL TESTS PASSED

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall $(VFLAGS) -f $(FILELIST) --top-module $(LINT_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# The log decides the result, not the exit status of the simulator
sim: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_TEXT)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* files.f */
+incdir+source
source/userCsrPkg.sv
source/csrAccessIf.sv
source/apbCsrPort.sv
source/fpUserCsr.sv
source/retireCounterCsr.sv
source/csrReadMux.sv
source/userCsrTop.sv
testbench/userCsrTb.sv

/* source/apbCsrPort.sv */
//////////////////////////////
// APB slave without wait states. pReady is the access phase itself
// The request is combinational from the APB inputs
//////////////////////////////

module apbCsrPort
  import userCsrPkg::*;
(
  input  logic     clk,
  input  logic     arstN,
  input  csrAdrT   pAddr,
  input  logic     pSel,
  input  logic     pEnable,
  input  logic     pWrite,
  input  xlenT     pWData,
  csrAccessIf.port csr,
  output logic     pReady
);

  // Phase of the transfer in this cycle, decoded from pSel and pEnable
  apbPhaseT curPhase;
  // Phase seen in the previous cycle
  apbPhaseT prevPhase;

  //////////////////////////////
  // Phase decode
  //////////////////////////////

  always_comb begin
    if (!pSel) begin
      curPhase = IDLE;
    end else if (!pEnable) begin
      curPhase = SETUP;
    end else begin
      curPhase = ACCESS;
    end
  end

  // Every CSR answers in the same cycle, so the slave is always ready
  assign pReady = (curPhase == ACCESS);

  //////////////////////////////
  // Request to the CSR units
  //////////////////////////////

  assign csr.adr    = pAddr;
  assign csr.access = (curPhase == ACCESS);
  // A write only counts in its access cycle
  assign csr.write  = (curPhase == ACCESS) && pWrite;
  assign csr.wrData = pWData;

  // Remember the phase so the checks below can see the sequence
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      prevPhase <= IDLE;
    end else begin
      prevPhase <= curPhase;
    end
  end

  //////////////////////////////
  // Protocol checks
  //////////////////////////////

  // pEnable may only rise while the slave is selected
  assert property (@(posedge clk) disable iff (!arstN)
    $rose(pEnable) |-> pSel);

  // An access cycle always follows exactly one setup cycle
  assert property (@(posedge clk) disable iff (!arstN)
    (curPhase == ACCESS) |-> (prevPhase == SETUP));

  // Address and direction hold from setup into access
  assert property (@(posedge clk) disable iff (!arstN)
    (curPhase == ACCESS) |-> ($stable(pAddr) && $stable(pWrite)));

endmodule

/* source/csrAccessIf.sv */
//////////////////////////////
// One decoded CSR request per cycle. Valid only while access is high
//////////////////////////////

interface csrAccessIf
  import userCsrPkg::*;
(
  input logic clk
);

  // CSR number of the current transfer
  csrAdrT adr;
  // High in the access cycle of a transfer
  logic   access;
  // High in the access cycle of a write transfer
  logic   write;
  // Data to store on a write
  xlenT   wrData;

  // The APB front end produces the request
  modport port (
    output adr,
    output access,
    output write,
    output wrData
  );

  // The CSR units decode and store from the request
  modport unit (
    input adr,
    input access,
    input write,
    input wrData
  );

  // The read mux only needs the address and the phase
  // It also takes the clock to sample its checks
  modport mux (
    input clk,
    input adr,
    input access
  );

endinterface

/* source/csrReadMux.sv */
//////////////////////////////
// Combinational read return. pRData and pSlvErr matter only in access
//////////////////////////////

module csrReadMux
  import userCsrPkg::*;
(
  csrAccessIf.mux csr,
  input  xlenT    fpRdVal,
  input  logic    fpClaim,
  input  xlenT    cntRdVal,
  input  logic    cntClaim,
  input  logic    writeViolation,
  output xlenT    pRData,
  output logic    pSlvErr
);

  logic anyClaim;

  assign anyClaim = fpClaim || cntClaim;

  //////////////////////////////
  // Read data
  //////////////////////////////

  // Unknown addresses return zero
  always_comb begin
    if (fpClaim) begin
      pRData = fpRdVal;
    end else if (cntClaim) begin
      pRData = cntRdVal;
    end else begin
      pRData = '0;
    end
  end

  // Error on an unclaimed address or on a write to a read-only CSR
  assign pSlvErr = csr.access && (!anyClaim || writeViolation);

  //////////////////////////////
  // Checks
  //////////////////////////////

  // The units own disjoint address sets
  assert property (@(posedge csr.clk)
    csr.access |-> !(fpClaim && cntClaim));

endmodule

/* source/fpUserCsr.sv */
//////////////////////////////
// fflags, frm and fcsr. fcsr is a view of the other two
// Without FP_SUPPORTED nothing is claimed and roundMode is zero
//////////////////////////////

`include "userCsr_macros.svh"

module fpUserCsr
  import userCsrPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  fflagsT    setFflags,
  csrAccessIf.unit  csr,
  output xlenT      rdVal,
  output logic      claim,
  output roundModeT roundMode
);

  generate
    if (`FP_SUPPORTED) begin : gFp
      fflagsT    fflags;
      roundModeT frm;
      logic      hitFflags;
      logic      hitFrm;
      logic      hitFcsr;
      logic      wrFflags;
      logic      wrFrm;

      //////////////////////////////
      // Address decode
      //////////////////////////////

      assign hitFflags = (csr.adr == `CSR_FFLAGS);
      assign hitFrm    = (csr.adr == `CSR_FRM);
      assign hitFcsr   = (csr.adr == `CSR_FCSR);
      assign claim     = hitFflags || hitFrm || hitFcsr;

      // fcsr writes both fields at once
      assign wrFflags = csr.write && (hitFflags || hitFcsr);
      assign wrFrm    = csr.write && (hitFrm || hitFcsr);

      //////////////////////////////
      // Registers
      //////////////////////////////

      always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
          fflags <= '0;
          frm    <= '0;
        end else begin
          // A software write wins over flags raised in the same cycle
          if (wrFflags) begin
            fflags <= csr.wrData[4:0];
          end else begin
            // Flags are sticky and only software clears them
            fflags <= fflags | setFflags;
          end
          if (wrFrm) begin
            // fcsr keeps the rounding mode in bits 7:5
            frm <= hitFcsr ? csr.wrData[7:5] : csr.wrData[2:0];
          end
        end
      end

      assign roundMode = frm;

      // Read values are zero-extended to the full word
      always_comb begin
        case (csr.adr)
          `CSR_FFLAGS: rdVal = {{(`XLEN-5){1'b0}}, fflags};
          `CSR_FRM:    rdVal = {{(`XLEN-3){1'b0}}, frm};
          `CSR_FCSR:   rdVal = {{(`XLEN-8){1'b0}}, frm, fflags};
          default:     rdVal = '0;
        endcase
      end

    end else begin : gNoFp
      // No floating point. Every address falls through as illegal
      assign claim     = 1'b0;
      assign rdVal     = '0;
      assign roundMode = '0;
    end
  endgenerate

  // Only the low 8 bits can ever be set
  assert property (@(posedge clk) disable iff (!arstN)
    rdVal[`XLEN-1:8] == '0);

endmodule

/* source/retireCounterCsr.sv */
//////////////////////////////
// 64-bit retired instruction count, read only over two CSRs
// Writes are flagged as violations and never change the count
//////////////////////////////

`include "userCsr_macros.svh"

module retireCounterCsr
  import userCsrPkg::*;
(
  input  logic     clk,
  input  logic     arstN,
  input  logic     retire,
  csrAccessIf.unit csr,
  output xlenT     rdVal,
  output logic     claim,
  output logic     writeViolation
);

  // Two CSR words wide
  logic [2*`XLEN-1:0] count;
  logic               hitLo;
  logic               hitHi;

  //////////////////////////////
  // Counter
  //////////////////////////////

  // One increment per retired instruction
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      count <= '0;
    end else if (retire) begin
      count <= count + 1'b1;
    end
  end

  //////////////////////////////
  // CSR access
  //////////////////////////////

  assign hitLo = (csr.adr == `CSR_INSTRET);
  assign hitHi = (csr.adr == `CSR_INSTRETH);
  assign claim = hitLo || hitHi;

  // The counter is user read-only, so any write to it is an error
  // csr.write already includes the access phase
  assign writeViolation = csr.write && claim;

  always_comb begin
    if (hitHi) begin
      rdVal = count[2*`XLEN-1:`XLEN];
    end else if (hitLo) begin
      rdVal = count[`XLEN-1:0];
    end else begin
      rdVal = '0;
    end
  end

  // The count only moves forward between resets
  assert property (@(posedge clk) disable iff (!arstN)
    count >= $past(count));

endmodule

/* source/userCsrPkg.sv */
//////////////////////////////
// Types shared by the CSR block. Widths follow the macros header
//////////////////////////////

`include "userCsr_macros.svh"

package userCsrPkg;

  // A 12-bit CSR number as it arrives on pAddr
  typedef logic [11:0] csrAdrT;

  // One data word as read or written over APB
  typedef logic [`XLEN-1:0] xlenT;

  // Accrued exception flags in the order NV DZ OF UF NX
  typedef logic [4:0] fflagsT;

  // Dynamic rounding mode as stored in frm
  typedef logic [2:0] roundModeT;

  // Phase of the APB transfer seen in one cycle
  // IDLE means pSel is low
  // SETUP is the first cycle of a transfer and ACCESS the second
  typedef enum logic [1:0] {
    IDLE   = 2'd0,
    SETUP  = 2'd1,
    ACCESS = 2'd2
  } apbPhaseT;

endpackage

/* source/userCsrTop.sv */
//////////////////////////////
// User CSR block with an APB slave port
// One transfer takes two clocks and never stalls
//////////////////////////////

module userCsrTop
  import userCsrPkg::*;
(
  input  logic      clk,
  input  logic      arstN,
  input  csrAdrT    pAddr,
  input  logic      pSel,
  input  logic      pEnable,
  input  logic      pWrite,
  input  xlenT      pWData,
  output xlenT      pRData,
  output logic      pReady,
  output logic      pSlvErr,
  input  fflagsT    setFflags,
  input  logic      retire,
  output roundModeT roundMode
);

  xlenT fpRdVal;
  logic fpClaim;
  xlenT cntRdVal;
  logic cntClaim;
  logic cntWriteViolation;

  // Decoded request shared by all units
  csrAccessIf csrBus (.clk(clk));

  apbCsrPort port_i (
    .clk     (clk),
    .arstN   (arstN),
    .pAddr   (pAddr),
    .pSel    (pSel),
    .pEnable (pEnable),
    .pWrite  (pWrite),
    .pWData  (pWData),
    .csr     (csrBus.port),
    .pReady  (pReady)
  );

  fpUserCsr fp_i (
    .clk       (clk),
    .arstN     (arstN),
    .setFflags (setFflags),
    .csr       (csrBus.unit),
    .rdVal     (fpRdVal),
    .claim     (fpClaim),
    .roundMode (roundMode)
  );

  retireCounterCsr cnt_i (
    .clk            (clk),
    .arstN          (arstN),
    .retire         (retire),
    .csr            (csrBus.unit),
    .rdVal          (cntRdVal),
    .claim          (cntClaim),
    .writeViolation (cntWriteViolation)
  );

  csrReadMux mux_i (
    .csr            (csrBus.mux),
    .fpRdVal        (fpRdVal),
    .fpClaim        (fpClaim),
    .cntRdVal       (cntRdVal),
    .cntClaim       (cntClaim),
    .writeViolation (cntWriteViolation),
    .pRData         (pRData),
    .pSlvErr        (pSlvErr)
  );

endmodule

/* source/userCsr_macros.svh */
//////////////////////////////
// XLEN is fixed at 32. The instreth CSR assumes this width
// Setting FP_SUPPORTED to 0 makes every floating-point CSR illegal
//////////////////////////////

`ifndef USERCSR_MACROS_SVH
`define USERCSR_MACROS_SVH

// Width of one CSR data word
`define XLEN 32

// Include the floating-point CSRs when 1
`define FP_SUPPORTED 1

//////////////////////////////
// User-level CSR numbers
//////////////////////////////

`define CSR_FFLAGS   12'h001
`define CSR_FRM      12'h002
`define CSR_FCSR     12'h003
`define CSR_INSTRET  12'hC02
`define CSR_INSTRETH 12'hC82

`endif

/* testbench/csrPatterns.txt */
# Columns: op adr data expRd expErr, all hex. op is W write, R read, S set flags, I retire
# For S the data column is the flag mask, for I it is the pulse count
R 001 00000000 00000000 0
R 002 00000000 00000000 0
R 003 00000000 00000000 0
R c02 00000000 00000000 0
R c82 00000000 00000000 0
# fcsr splits into frm and fflags
W 003 000000b5 00000000 0
R 003 00000000 000000b5 0
R 002 00000000 00000005 0
R 001 00000000 00000015 0
W 003 ffffff4a 00000000 0
R 003 00000000 0000004a 0
R 002 00000000 00000002 0
R 001 00000000 0000000a 0
# Sticky flags and a clearing write
W 001 00000000 00000000 0
S 000 00000001 00000000 0
S 000 00000004 00000000 0
S 000 00000010 00000000 0
R 001 00000000 00000015 0
R 003 00000000 00000055 0
W 001 00000008 00000000 0
R 001 00000000 00000008 0
W 002 0000000f 00000000 0
R 003 00000000 000000e8 0
# Retire counter is read only
I 000 00000019 00000000 0
R c02 00000000 00000019 0
R c82 00000000 00000000 0
W c02 12345678 00000000 1
R c02 00000000 00000019 0
I 000 00000003 00000000 0
R c02 00000000 0000001c 0
W c82 00000001 00000000 1
R c82 00000000 00000000 0
# Unknown addresses
R 004 00000000 00000000 1
W 004 000000ff 00000000 1
R 7ff 00000000 00000000 1
W c00 00000001 00000000 1
W 000 000000e0 00000000 1
R 003 00000000 000000e8 0
R c02 00000000 0000001c 0

/* testbench/userCsrTb.sv */
//////////////////////////////
// Runs testbench/csrPatterns.txt on userCsrTop, which must be run from the project root
// The expected values in the file assume FP_SUPPORTED is 1
//////////////////////////////

`include "userCsr_macros.svh"

module userCsrTb
  import userCsrPkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  localparam string PATTERN_FILE  = "testbench/csrPatterns.txt";
  localparam int    RANDOM_ROUNDS = 6;

  logic      clk;
  logic      arstN;
  csrAdrT    pAddr;
  logic      pSel;
  logic      pEnable;
  logic      pWrite;
  xlenT      pWData;
  xlenT      pRData;
  logic      pReady;
  logic      pSlvErr;
  fflagsT    setFflags;
  logic      retire;
  roundModeT roundMode;

  // Patterns as loaded from the file, one entry per line
  logic [7:0] patOp[$];
  csrAdrT     patAdr[$];
  xlenT       patData[$];
  xlenT       patRd[$];
  logic       patErr[$];

  // Reference model state
  fflagsT      refFflags;
  roundModeT   refFrm;
  logic [63:0] refCount;

  int          errorCount;
  int          checkCount;
  int          budgetCycles = 0;
  logic [31:0] lfsrState;

  userCsrTop dut_i (
    .clk       (clk),
    .arstN     (arstN),
    .pAddr     (pAddr),
    .pSel      (pSel),
    .pEnable   (pEnable),
    .pWrite    (pWrite),
    .pWData    (pWData),
    .pRData    (pRData),
    .pReady    (pReady),
    .pSlvErr   (pSlvErr),
    .setFflags (setFflags),
    .retire    (retire),
    .roundMode (roundMode)
  );

  // 100 ns period
  always #50 clk = ~clk;

  //////////////////////////////
  // Checks and random numbers
  //////////////////////////////

  task automatic checkValue(input string sigName, input csrAdrT adr, input xlenT got,
                            input xlenT exp);
    checkCount++;
    if (got !== exp) begin
      errorCount++;
      $display("** Error: %s at CSR 0x%03h is 0x%08h, expected 0x%08h at %0t",
               sigName, adr, got, exp, $time);
    end
  endtask

  // The file and the model must predict the same response
  task automatic comparePattern(input int idx, input string field, input xlenT fileVal,
                                input xlenT refVal);
    checkCount++;
    if (fileVal !== refVal) begin
      errorCount++;
      $display("** Error: pattern %0d %s is 0x%08h in the file, 0x%08h in the model",
               idx, field, fileVal, refVal);
    end
  endtask

  // Galois LFSR for x^32 + x^22 + x^2 + x + 1, shifting right
  function automatic logic [31:0] lfsrNext(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 32'h8020_0003;
    end
    return n;
  endfunction

  // One LFSR step per bit of the word
  task automatic drawRandom(output xlenT w);
    for (int b = 0; b < `XLEN; b++) begin
      lfsrState = lfsrNext(lfsrState);
      w[b] = lfsrState[0];
    end
  endtask

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic refClaims(input csrAdrT adr);
    logic fpHit;
    fpHit = (adr == `CSR_FFLAGS) || (adr == `CSR_FRM) || (adr == `CSR_FCSR);
    return (fpHit && (`FP_SUPPORTED != 0)) || (adr == `CSR_INSTRET) ||
           (adr == `CSR_INSTRETH);
  endfunction

  // Unknown CSRs and writes to the counter are errors
  function automatic logic refError(input csrAdrT adr, input logic wr);
    return !refClaims(adr) || (wr && ((adr == `CSR_INSTRET) || (adr == `CSR_INSTRETH)));
  endfunction

  function automatic xlenT refRead(input csrAdrT adr);
    xlenT v;
    v = '0;
    if (refClaims(adr)) begin
      case (adr)
        `CSR_FFLAGS:   v[4:0] = refFflags;
        `CSR_FRM:      v[2:0] = refFrm;
        `CSR_FCSR:     v[7:0] = {refFrm, refFflags};
        `CSR_INSTRET:  v = refCount[31:0];
        `CSR_INSTRETH: v = refCount[63:32];
        default:       v = '0;
      endcase
    end
    return v;
  endfunction

  task automatic refWrite(input csrAdrT adr, input xlenT data);
    case (adr)
      `CSR_FFLAGS: refFflags = data[4:0];
      `CSR_FRM:    refFrm = data[2:0];
      `CSR_FCSR: begin
        // Rounding mode sits above the five flags
        refFrm    = data[7:5];
        refFflags = data[4:0];
      end
      default: ;
    endcase
  endtask

  //////////////////////////////
  // Drivers
  //////////////////////////////

  // Setup, access and one idle cycle; outputs are sampled on the falling edge
  task automatic applyTransfer(input logic wr, input csrAdrT adr, input xlenT data,
                               output xlenT rd, output logic err);
    @(posedge clk);
    #5;
    pSel    = 1'b1;
    pEnable = 1'b0;
    pWrite  = wr;
    pAddr   = adr;
    pWData  = data;
    @(negedge clk);
    checkValue("pReady", adr, pReady, 1'b0);
    @(posedge clk);
    #5;
    pEnable = 1'b1;
    @(negedge clk);
    checkValue("pReady", adr, pReady, 1'b1);
    rd  = pRData;
    err = pSlvErr;
    // A write lands on the edge that ends the access cycle
    @(posedge clk);
    #5;
    pSel    = 1'b0;
    pEnable = 1'b0;
    pWrite  = 1'b0;
    @(negedge clk);
    checkValue("pReady", adr, pReady, 1'b0);
    checkValue("pSlvErr", adr, pSlvErr, 1'b0);
  endtask

  task automatic checkedTransfer(input logic wr, input csrAdrT adr, input xlenT data,
                                 input xlenT expRd, input logic expErr);
    xlenT rd;
    logic err;
    applyTransfer(wr, adr, data, rd, err);
    if (!wr) begin
      checkValue("pRData", adr, rd, expRd);
    end
    checkValue("pSlvErr", adr, err, expErr);
    if (wr && !refError(adr, wr)) begin
      refWrite(adr, data);
    end
  endtask

  // setFlags is high across exactly one rising edge
  task automatic holdFlagSet(input fflagsT flags);
    @(posedge clk);
    #5;
    setFflags = flags;
    @(negedge clk);
    checkValue("pReady", '0, pReady, 1'b0);
    @(posedge clk);
    #5;
    setFflags = '0;
    @(negedge clk);
  endtask

  // retire stays high across n rising edges
  task automatic pulseRetire(input int n);
    for (int k = 0; k < n; k++) begin
      @(posedge clk);
      #5;
      retire = 1'b1;
    end
    @(posedge clk);
    #5;
    retire = 1'b0;
    @(negedge clk);
  endtask

  //////////////////////////////
  // Pattern file and test flow
  //////////////////////////////

  task automatic loadPatterns(output logic ok);
    int     fd;
    int     c;
    int     n;
    csrAdrT a;
    xlenT   d;
    xlenT   r;
    xlenT   e;
    ok = 1'b1;
    fd = $fopen(PATTERN_FILE, "r");
    if (fd == 0) begin
      ok = 1'b0;
    end else begin
      c = $fgetc(fd);
      while (c != -1) begin
        if (c == "#") begin
          // Comments run to the end of the line
          while ((c != -1) && (c != "\n")) begin
            c = $fgetc(fd);
          end
        end else if ((c != " ") && (c != "\t") && (c != "\n") && (c != "\r")) begin
          // First character of a line is the opcode
          n = $fscanf(fd, "%h %h %h %h", a, d, r, e);
          if (n != 4) begin
            $display("Pattern entry %0d in the file is malformed", patOp.size());
            ok = 1'b0;
            c  = -1;
          end else begin
            patOp.push_back(c[7:0]);
            patAdr.push_back(a);
            patData.push_back(d);
            patRd.push_back(r);
            patErr.push_back(e[0]);
          end
        end
        if (c != -1) begin
          c = $fgetc(fd);
        end
      end
      $fclose(fd);
      if (patOp.size() == 0) begin
        $display("The pattern file holds no patterns");
        ok = 1'b0;
      end
    end
  endtask

  task automatic runPattern(input int idx);
    logic wr;
    xlenT predRd;
    logic predErr;
    case (patOp[idx])
      "W", "R": begin
        wr      = (patOp[idx] == "W");
        predRd  = refRead(patAdr[idx]);
        predErr = refError(patAdr[idx], wr);
        if (!wr) begin
          comparePattern(idx, "pRData", patRd[idx], predRd);
        end
        comparePattern(idx, "pSlvErr", patErr[idx], predErr);
        checkedTransfer(wr, patAdr[idx], patData[idx], patRd[idx], patErr[idx]);
      end
      "S": begin
        holdFlagSet(patData[idx][4:0]);
        refFflags = refFflags | patData[idx][4:0];
      end
      "I": begin
        pulseRetire(int'(patData[idx]));
        refCount = refCount + patData[idx];
      end
      default: begin
        errorCount++;
        $display("Pattern %0d has the unknown opcode %c", idx, patOp[idx]);
      end
    endcase
    checkValue("roundMode", patAdr[idx], roundMode, refFrm);
  endtask

  // Random writes to fcsr, frm and to any CSR number, each read back
  task automatic runRandomWrites();
    xlenT   data;
    xlenT   adrWord;
    csrAdrT adr;
    for (int i = 0; i < RANDOM_ROUNDS; i++) begin
      drawRandom(data);
      drawRandom(adrWord);
      if (i % 3 == 0) begin
        adr = `CSR_FCSR;
      end else if (i % 3 == 1) begin
        adr = `CSR_FRM;
      end else begin
        adr = adrWord[11:0];
      end
      checkedTransfer(1'b1, adr, data, '0, refError(adr, 1'b1));
      checkedTransfer(1'b0, adr, '0, refRead(adr), refError(adr, 1'b0));
      checkedTransfer(1'b0, `CSR_FCSR, '0, refRead(`CSR_FCSR), refError(`CSR_FCSR, 1'b0));
      checkValue("roundMode", adr, roundMode, refFrm);
    end
  endtask

  initial begin
    logic loadOk;
    int   budget;
    clk        = 1'b0;
    arstN      = 1'b0;
    pAddr      = '0;
    pSel       = 1'b0;
    pEnable    = 1'b0;
    pWrite     = 1'b0;
    pWData     = '0;
    setFflags  = '0;
    retire     = 1'b0;
    refFflags  = '0;
    refFrm     = '0;
    refCount   = '0;
    errorCount = 0;
    checkCount = 0;
    lfsrState  = 32'h37b6;
    loadPatterns(loadOk);
    // Four cycles per operation plus the retire pulses, with some slack
    budget = 50 + RANDOM_ROUNDS * 12;
    foreach (patOp[i]) begin
      budget += 4 + ((patOp[i] == "I") ? int'(patData[i]) : 0);
    end
    budgetCycles = budget;
    repeat (4) @(posedge clk);
    #5;
    arstN = 1'b1;
    if (loadOk) begin
      @(negedge clk);
      checkValue("roundMode", '0, roundMode, '0);
      foreach (patOp[i]) begin
        runPattern(i);
      end
      runRandomWrites();
    end else begin
      errorCount++;
      $display("The pattern file %s could not be read", PATTERN_FILE);
    end
    $display("Checks: %0d, errors: %0d", checkCount, errorCount);
    if (errorCount == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // Watchdog sized from the loaded patterns
  initial begin
    wait (budgetCycles > 0);
    repeat (budgetCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles before the run finished", budgetCycles);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule
